// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bpu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLIST     ?= compile.f
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+sim
hw/bpu_arch_pkg.sv
hw/bpu_table_pkg.sv
hw/bpu_lookup.sv
hw/bpu_tables.sv
hw/bpu_ras.sv
hw/bpu_target_queue.sv
hw/bpu_top.sv
sim/bpu_tb.sv

// ==== hw/bpu_arch_pkg.sv ====
// Fetch and ISA types
package bpu_arch_pkg;

  // byte address of an instruction
  typedef logic [31:0] pc_t;

  // pc without its two low bits
  typedef logic [29:0] waddr_t;

  // one bit per instruction of a fetch group
  typedef logic [3:0] slot_mask_t;

  // branch kind as stored in the BTB
  typedef logic [1:0] jump_type_t;

  localparam jump_type_t JT_DIRECT = 2'd0;
  localparam jump_type_t JT_CALL   = 2'd1;
  localparam jump_type_t JT_RETURN = 2'd2;

  localparam int GROUP_SLOTS = 4;  // aligned 16-byte group

endpackage

// ==== hw/bpu_lookup.sv ====
// Fetch group prediction
`timescale 1ns/1ps

module bpu_lookup #(
  parameter int BTB_IDX_W = 9
) (
  input  bpu_arch_pkg::pc_t          pc,
  input  bpu_arch_pkg::slot_mask_t   rd_valid,
  input  bpu_table_pkg::tag_t        rd_tag    [bpu_arch_pkg::GROUP_SLOTS],
  input  bpu_arch_pkg::jump_type_t   rd_type   [bpu_arch_pkg::GROUP_SLOTS],
  input  bpu_arch_pkg::waddr_t       rd_target [bpu_arch_pkg::GROUP_SLOTS],
  input  bpu_table_pkg::ctr_t        rd_ctr    [bpu_arch_pkg::GROUP_SLOTS],
  input  bpu_arch_pkg::waddr_t       ras_top,
  output bpu_arch_pkg::pc_t          next_pc,
  output bpu_arch_pkg::slot_mask_t   pc_valid,
  output bpu_arch_pkg::slot_mask_t   pc_is_jump,
  output logic [BTB_IDX_W-1:0]       rd_idx    [bpu_arch_pkg::GROUP_SLOTS],
  output logic                       predict_push,
  output bpu_arch_pkg::waddr_t       predict_target
);
  import bpu_arch_pkg::*;
  import bpu_table_pkg::*;

  logic [BTB_IDX_W-1:0] base_idx;
  tag_t                 fetch_tag;
  slot_mask_t           group_mask;
  logic                 hit;
  logic [1:0]           hit_slot;

  assign base_idx  = {pc[BTB_IDX_W+1:4], 2'b00};  // first slot of the group
  assign fetch_tag = pc_tag(pc);

  always_comb
  begin
    for (int s = 0; s < GROUP_SLOTS; s++)
    begin
      rd_idx[s] = base_idx + BTB_IDX_W'(s);
    end
  end

  // slots at or after the fetch pc
  always_comb
  begin
    case (pc[3:2])
      2'b00:   group_mask = 4'b1111;
      2'b01:   group_mask = 4'b1110;
      2'b10:   group_mask = 4'b1100;
      default: group_mask = 4'b1000;
    endcase
  end

  // lowest qualifying slot wins
  always_comb
  begin
    hit      = 1'b0;
    hit_slot = 2'd0;
    for (int s = 0; s < GROUP_SLOTS; s++)
    begin
      if (!hit && group_mask[s] && rd_valid[s] && ctr_taken(rd_ctr[s]) &&
          rd_tag[s] == fetch_tag)
      begin
        hit      = 1'b1;
        hit_slot = 2'(s);
      end
    end
  end

  always_comb
  begin
    if (hit)
    begin
      pc_is_jump = slot_mask_t'(1) << hit_slot;
      pc_valid   = group_mask & (pc_is_jump | (pc_is_jump - 1'b1));  // up to the jump
      if (rd_type[hit_slot] == JT_RETURN)
        next_pc = {ras_top, 2'b00};
      else
        next_pc = {rd_target[hit_slot], 2'b00};
    end
    else
    begin
      pc_is_jump = '0;
      pc_valid   = group_mask;
      next_pc    = {pc[31:4] + 28'd1, 4'b0000};  // next aligned group
    end
  end

  assign predict_push   = hit;
  assign predict_target = next_pc[31:2];

endmodule

// ==== hw/bpu_ras.sv ====
// Return address stack
`timescale 1ns/1ps

module bpu_ras #(
  parameter int RAS_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 call_1,
  input  logic                 ret_1,
  input  logic                 ret_mispredict_1,
  input  bpu_arch_pkg::pc_t    call_pc_1,
  input  logic                 call_2,
  input  logic                 ret_2,
  input  logic                 ret_mispredict_2,
  input  bpu_arch_pkg::pc_t    call_pc_2,
  output bpu_arch_pkg::waddr_t ras_top
);
  import bpu_arch_pkg::*;

  localparam int PTR_W = $clog2(RAS_DEPTH);

  waddr_t           stack_mem [RAS_DEPTH];
  logic [PTR_W-1:0] count;  // wraps and overwrites old entries
  logic [PTR_W-1:0] top_ptr;
  logic [1:0]       call;
  logic [1:0]       pop;
  pc_t              call_pc [2];

  assign call       = {call_2, call_1};
  assign pop        = {ret_2 && !ret_mispredict_2, ret_1 && !ret_mispredict_1};
  assign call_pc[0] = call_pc_1;
  assign call_pc[1] = call_pc_2;

  assign top_ptr = count - 1'b1;
  assign ras_top = stack_mem[top_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else
    begin
      for (int n = 0; n < 2; n++)
      begin
        if (call[n])
          count <= count + 1'b1;
        else if (pop[n])
          count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int n = 0; n < 2; n++)
    begin
      if (call[n])
        stack_mem[count] <= call_pc[n][31:2] + 30'd1;  // return lands after the call
    end
  end

endmodule

// ==== hw/bpu_table_pkg.sv ====
// BTB entry and counter definitions
package bpu_table_pkg;

  localparam int TAG_W = 10;

  typedef logic [TAG_W-1:0] tag_t;

  // 2-bit saturating direction counter
  typedef logic [1:0] ctr_t;

  localparam ctr_t CTR_MIN        = 2'd0;
  localparam ctr_t CTR_WEAK_TAKEN = 2'd2;  // new entries start here
  localparam ctr_t CTR_MAX        = 2'd3;

  // folds the upper pc bits into a short tag
  function automatic tag_t pc_tag(input bpu_arch_pkg::pc_t pc);
    tag_t tag;
    tag = pc[21:12] ^ pc[31:22];
    return tag;
  endfunction

  // taken when the counter is in the upper half
  function automatic logic ctr_taken(input ctr_t ctr);
    logic taken;
    taken = (ctr >= CTR_WEAK_TAKEN);
    return taken;
  endfunction

endpackage

// ==== hw/bpu_tables.sv ====
// BTB and counter tables
`timescale 1ns/1ps

module bpu_tables #(
  parameter int BTB_IDX_W = 9
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [BTB_IDX_W-1:0]       rd_idx    [bpu_arch_pkg::GROUP_SLOTS],
  output bpu_arch_pkg::slot_mask_t   rd_valid,
  output bpu_table_pkg::tag_t        rd_tag    [bpu_arch_pkg::GROUP_SLOTS],
  output bpu_arch_pkg::jump_type_t   rd_type   [bpu_arch_pkg::GROUP_SLOTS],
  output bpu_arch_pkg::waddr_t       rd_target [bpu_arch_pkg::GROUP_SLOTS],
  output bpu_table_pkg::ctr_t        rd_ctr    [bpu_arch_pkg::GROUP_SLOTS],
  input  logic                       wr_jump_1,
  input  logic                       wr_taken_1,
  input  bpu_arch_pkg::pc_t          wr_pc_1,
  input  bpu_arch_pkg::pc_t          wr_target_1,
  input  bpu_arch_pkg::jump_type_t   wr_type_1,
  input  logic                       wr_jump_2,
  input  logic                       wr_taken_2,
  input  bpu_arch_pkg::pc_t          wr_pc_2,
  input  bpu_arch_pkg::pc_t          wr_target_2,
  input  bpu_arch_pkg::jump_type_t   wr_type_2,
  output logic                       entry_valid_1,
  output logic                       entry_valid_2
);
  import bpu_arch_pkg::*;
  import bpu_table_pkg::*;

  localparam int ENTRIES  = 2 ** BTB_IDX_W;
  localparam int WR_SLOTS = 2;

  logic [ENTRIES-1:0] valid_q;
  tag_t               tag_mem    [ENTRIES];
  jump_type_t         type_mem   [ENTRIES];
  waddr_t             target_mem [ENTRIES];
  ctr_t               ctr_mem    [ENTRIES];

  logic [WR_SLOTS-1:0]  wr_jump;
  logic [WR_SLOTS-1:0]  wr_taken;
  logic [WR_SLOTS-1:0]  entry_hit;
  logic [WR_SLOTS-1:0]  alloc;
  logic [WR_SLOTS-1:0]  train;
  pc_t                  wr_pc     [WR_SLOTS];
  pc_t                  wr_target [WR_SLOTS];
  jump_type_t           wr_type   [WR_SLOTS];
  logic [BTB_IDX_W-1:0] widx      [WR_SLOTS];
  tag_t                 wtag      [WR_SLOTS];
  ctr_t                 ctr_next  [WR_SLOTS];

  assign wr_jump  = {wr_jump_2, wr_jump_1};
  assign wr_taken = {wr_taken_2, wr_taken_1};

  assign wr_pc[0]     = wr_pc_1;
  assign wr_pc[1]     = wr_pc_2;
  assign wr_target[0] = wr_target_1;
  assign wr_target[1] = wr_target_2;
  assign wr_type[0]   = wr_type_1;
  assign wr_type[1]   = wr_type_2;

  always_comb
  begin
    for (int s = 0; s < GROUP_SLOTS; s++)
    begin
      rd_valid[s]  = valid_q[rd_idx[s]];
      rd_tag[s]    = tag_mem[rd_idx[s]];
      rd_type[s]   = type_mem[rd_idx[s]];
      rd_target[s] = target_mem[rd_idx[s]];
      rd_ctr[s]    = ctr_mem[rd_idx[s]];
    end
  end

  // per-slot hit test and counter step from pre-edge state
  always_comb
  begin
    for (int n = 0; n < WR_SLOTS; n++)
    begin
      widx[n]      = wr_pc[n][BTB_IDX_W+1:2];
      wtag[n]      = pc_tag(wr_pc[n]);
      entry_hit[n] = valid_q[widx[n]] && (tag_mem[widx[n]] == wtag[n]);
      alloc[n]     = wr_jump[n] && wr_taken[n] && !entry_hit[n];
      train[n]     = wr_jump[n] && entry_hit[n];
      if (wr_taken[n])
        ctr_next[n] = (ctr_mem[widx[n]] == CTR_MAX) ? CTR_MAX : ctr_mem[widx[n]] + 1'b1;
      else
        ctr_next[n] = (ctr_mem[widx[n]] == CTR_MIN) ? CTR_MIN : ctr_mem[widx[n]] - 1'b1;
    end
  end

  assign entry_valid_1 = valid_q[widx[0]];
  assign entry_valid_2 = valid_q[widx[1]];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q <= '0;
    end
    else
    begin
      for (int n = 0; n < WR_SLOTS; n++)
      begin
        if (alloc[n])
          valid_q[widx[n]] <= 1'b1;
      end
    end
  end

  // loop order lets slot 2 win a shared index
  always_ff @(posedge clk)
  begin
    for (int n = 0; n < WR_SLOTS; n++)
    begin
      if (alloc[n])
      begin
        ctr_mem[widx[n]]    <= CTR_WEAK_TAKEN;
        tag_mem[widx[n]]    <= wtag[n];
        type_mem[widx[n]]   <= wr_type[n];
        target_mem[widx[n]] <= wr_target[n][31:2];
      end
      else if (train[n])
      begin
        ctr_mem[widx[n]] <= ctr_next[n];
        if (wr_taken[n])
          target_mem[widx[n]] <= wr_target[n][31:2];  // follow a moved target
      end
    end
  end

endmodule

// ==== hw/bpu_target_queue.sv ====
// Predicted target queue and flush check
`timescale 1ns/1ps

module bpu_target_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 predict_push,
  input  bpu_arch_pkg::waddr_t predict_target,
  input  logic                 install,
  input  logic                 es_flush_1,
  input  logic                 es_flush_2,
  input  logic                 check_1,
  input  bpu_arch_pkg::pc_t    check_target_1,
  input  logic                 entry_valid_1,
  input  logic                 check_2,
  input  bpu_arch_pkg::pc_t    check_target_2,
  input  logic                 entry_valid_2,
  output logic                 bpu_flush,
  output bpu_arch_pkg::pc_t    bpu_jump_pc,
  output logic                 fail_1,
  output logic                 fail_2
);
  import bpu_arch_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  waddr_t                 q_mem [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0] q_valid;
  logic [PTR_W-1:0]       head;
  logic [PTR_W-1:0]       tail;
  logic                   active_1;
  logic                   active_2;
  logic                   pop;
  logic                   push;
  logic                   clear;

  assign active_1 = check_1 && entry_valid_1 && q_valid[head];
  assign active_2 = check_2 && entry_valid_2 && q_valid[head];

  assign fail_1 = active_1 && (check_target_1[31:2] != q_mem[head]);
  assign fail_2 = active_2 && (check_target_2[31:2] != q_mem[head]);

  assign bpu_flush   = fail_1 || fail_2;
  assign bpu_jump_pc = fail_1 ? check_target_1 : check_target_2;  // older slot first

  assign pop   = (active_1 && !fail_1) || (active_2 && !fail_2);
  assign push  = predict_push && !install && !q_valid[tail];  // drop when full
  assign clear = es_flush_1 || es_flush_2 || bpu_flush;

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      q_valid <= '0;
      head    <= '0;
      tail    <= '0;
    end
    else
    begin
      if (pop)
      begin
        q_valid[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      if (push)
      begin
        q_valid[tail] <= 1'b1;
        tail          <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      q_mem[tail] <= predict_target;
  end

endmodule

// ==== hw/bpu_top.sv ====
// Branch prediction unit
`timescale 1ns/1ps

module bpu_top #(
  parameter int BTB_IDX_W   = 9,
  parameter int RAS_DEPTH   = 8,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  bpu_arch_pkg::pc_t        pc,
  input  logic                     install,
  output bpu_arch_pkg::pc_t        next_pc,
  output bpu_arch_pkg::slot_mask_t pc_valid,
  output bpu_arch_pkg::slot_mask_t pc_is_jump,
  input  logic                     es_flush_1,
  input  logic                     es_excp_1,
  input  logic                     es_etrn_1,
  input  bpu_arch_pkg::pc_t        es_pc_1,
  input  logic                     es_may_jump_1,
  input  logic                     es_need_jump_1,
  input  logic                     es_pre_fail_1,
  input  bpu_arch_pkg::pc_t        es_target_1,
  input  bpu_arch_pkg::jump_type_t es_jump_type_1,
  input  logic                     es_flush_2,
  input  logic                     es_excp_2,
  input  logic                     es_etrn_2,
  input  bpu_arch_pkg::pc_t        es_pc_2,
  input  logic                     es_may_jump_2,
  input  logic                     es_need_jump_2,
  input  logic                     es_pre_fail_2,
  input  bpu_arch_pkg::pc_t        es_target_2,
  input  bpu_arch_pkg::jump_type_t es_jump_type_2,
  output logic                     bpu_flush,
  output bpu_arch_pkg::pc_t        bpu_jump_pc
);
  import bpu_arch_pkg::*;
  import bpu_table_pkg::*;

  logic [BTB_IDX_W-1:0] rd_idx [GROUP_SLOTS];
  slot_mask_t           rd_valid;
  tag_t                 rd_tag    [GROUP_SLOTS];
  jump_type_t           rd_type   [GROUP_SLOTS];
  waddr_t               rd_target [GROUP_SLOTS];
  ctr_t                 rd_ctr    [GROUP_SLOTS];
  waddr_t               ras_top;
  waddr_t               predict_target;
  logic                 predict_push;
  logic                 wr_jump_1;
  logic                 wr_jump_2;
  logic                 taken_1;
  logic                 taken_2;
  logic                 entry_valid_1;
  logic                 entry_valid_2;
  logic                 fail_1;
  logic                 fail_2;

  // resolved jump not squashed by a trap or ertn
  assign wr_jump_1 = es_may_jump_1 && !es_excp_1 && !es_etrn_1;
  assign wr_jump_2 = es_may_jump_2 && !es_excp_2 && !es_etrn_2;
  assign taken_1   = wr_jump_1 && es_need_jump_1;
  assign taken_2   = wr_jump_2 && es_need_jump_2;

  bpu_lookup #(.BTB_IDX_W(BTB_IDX_W)) lookup_i (
    .pc(pc), .rd_valid(rd_valid), .rd_tag(rd_tag), .rd_type(rd_type),
    .rd_target(rd_target), .rd_ctr(rd_ctr), .ras_top(ras_top),
    .next_pc(next_pc), .pc_valid(pc_valid), .pc_is_jump(pc_is_jump), .rd_idx(rd_idx),
    .predict_push(predict_push), .predict_target(predict_target)
  );

  bpu_tables #(.BTB_IDX_W(BTB_IDX_W)) tables_i (
    .clk(clk), .reset(reset), .rd_idx(rd_idx), .rd_valid(rd_valid), .rd_tag(rd_tag),
    .rd_type(rd_type), .rd_target(rd_target), .rd_ctr(rd_ctr),
    .wr_jump_1(wr_jump_1), .wr_taken_1(es_need_jump_1), .wr_pc_1(es_pc_1),
    .wr_target_1(es_target_1), .wr_type_1(es_jump_type_1),
    .wr_jump_2(wr_jump_2), .wr_taken_2(es_need_jump_2), .wr_pc_2(es_pc_2),
    .wr_target_2(es_target_2), .wr_type_2(es_jump_type_2),
    .entry_valid_1(entry_valid_1), .entry_valid_2(entry_valid_2)
  );

  bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) ras_i (
    .clk(clk), .reset(reset),
    .call_1(taken_1 && es_jump_type_1 == JT_CALL),
    .ret_1(taken_1 && es_jump_type_1 == JT_RETURN),
    .ret_mispredict_1(fail_1), .call_pc_1(es_pc_1),
    .call_2(taken_2 && es_jump_type_2 == JT_CALL),
    .ret_2(taken_2 && es_jump_type_2 == JT_RETURN),
    .ret_mispredict_2(fail_2), .call_pc_2(es_pc_2),
    .ras_top(ras_top)
  );

  bpu_target_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
    .clk(clk), .reset(reset), .predict_push(predict_push),
    .predict_target(predict_target), .install(install),
    .es_flush_1(es_flush_1), .es_flush_2(es_flush_2),
    .check_1(taken_1 && !es_pre_fail_1), .check_target_1(es_target_1),
    .entry_valid_1(entry_valid_1),
    .check_2(taken_2 && !es_pre_fail_2), .check_target_2(es_target_2),
    .entry_valid_2(entry_valid_2),
    .bpu_flush(bpu_flush), .bpu_jump_pc(bpu_jump_pc), .fail_1(fail_1), .fail_2(fail_2)
  );

endmodule

// ==== sim/bpu_ref_model.svh ====
// Prediction unit reference model
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

localparam int REF_ENTRIES = 512;
localparam int REF_DEPTH   = 8;

bit         ref_valid [REF_ENTRIES];
logic [9:0] ref_tag   [REF_ENTRIES];
jump_type_t ref_type  [REF_ENTRIES];
waddr_t     ref_tgt   [REF_ENTRIES];
logic [1:0] ref_ctr   [REF_ENTRIES];
waddr_t     ref_stack [REF_DEPTH];
logic [2:0] ref_sp;
waddr_t     ref_q     [REF_DEPTH];
bit         ref_qv    [REF_DEPTH];
logic [2:0] ref_qh;
logic [2:0] ref_qt;

function automatic logic [9:0] ref_tag_of(input pc_t p);
  return p[21:12] ^ p[31:22];
endfunction

function automatic logic [8:0] ref_idx_of(input pc_t p);
  return p[10:2];
endfunction

function automatic void ref_reset();
  for (int i = 0; i < REF_ENTRIES; i++)
    ref_valid[i] = 1'b0;
  for (int i = 0; i < REF_DEPTH; i++)
    ref_qv[i] = 1'b0;
  ref_sp = '0;
  ref_qh = '0;
  ref_qt = '0;
endfunction

// expected lookup result for one fetch pc
function automatic void ref_fetch(input pc_t p, output pc_t npc, output slot_mask_t vmask,
                                  output slot_mask_t jmask);
  slot_mask_t group;
  logic [8:0] i;
  int         hit_s;
  group = 4'b1111 << p[3:2];
  hit_s = -1;
  for (int s = 0; s < 4; s++)
  begin
    i = {p[10:4], 2'(s)};
    if (hit_s < 0 && group[s] && ref_valid[i] && ref_ctr[i] >= 2'd2 &&
        ref_tag[i] == ref_tag_of(p))
      hit_s = s;
  end
  if (hit_s < 0)
  begin
    npc   = (p & ~32'hf) + 32'd16;
    vmask = group;
    jmask = 4'b0000;
  end
  else
  begin
    i     = {p[10:4], 2'(hit_s)};
    jmask = 4'b0001 << hit_s;
    vmask = group & slot_mask_t'((5'd2 << hit_s) - 5'd1);
    if (ref_type[i] == JT_RETURN)
      npc = {ref_stack[ref_sp - 3'd1], 2'b00};
    else
      npc = {ref_tgt[i], 2'b00};
  end
endfunction

function automatic void ref_check(input int n, output bit active, output bit fail);
  bit taken;
  taken  = es_may_jump[n] && !es_excp[n] && !es_etrn[n] && es_need_jump[n];
  active = taken && !es_pre_fail[n] && ref_valid[ref_idx_of(es_pc[n])] && ref_qv[ref_qh];
  fail   = active && (es_target[n][31:2] != ref_q[ref_qh]);
endfunction

function automatic void ref_flush(output bit flush, output pc_t jpc);
  bit a1;
  bit f1;
  bit a2;
  bit f2;
  ref_check(1, a1, f1);
  ref_check(2, a2, f2);
  flush = f1 || f2;
  jpc   = f1 ? es_target[1] : es_target[2];  // older slot first
endfunction

// state change at the coming rising edge
function automatic void ref_step();
  bit         act [1:2];
  bit         fl  [1:2];
  bit         jmp [1:2];
  bit         hit [1:2];
  logic [8:0] idx [1:2];
  logic [1:0] ctr_new [1:2];
  logic [2:0] sp0;
  bit         fl_any;
  bit         pop_q;
  bit         push_q;
  pc_t        npc;
  pc_t        jpc;
  slot_mask_t vm;
  slot_mask_t jm;
  ref_fetch(pc, npc, vm, jm);
  ref_flush(fl_any, jpc);
  for (int n = 1; n <= 2; n++)
  begin
    ref_check(n, act[n], fl[n]);
    jmp[n] = es_may_jump[n] && !es_excp[n] && !es_etrn[n];
    idx[n] = ref_idx_of(es_pc[n]);
    hit[n] = ref_valid[idx[n]] && ref_tag[idx[n]] == ref_tag_of(es_pc[n]);
    if (es_need_jump[n])
      ctr_new[n] = (ref_ctr[idx[n]] == 2'd3) ? 2'd3 : ref_ctr[idx[n]] + 2'd1;
    else
      ctr_new[n] = (ref_ctr[idx[n]] == 2'd0) ? 2'd0 : ref_ctr[idx[n]] - 2'd1;
  end
  pop_q  = (act[1] && !fl[1]) || (act[2] && !fl[2]);
  push_q = (jm != 4'b0000) && !install && !ref_qv[ref_qt];
  sp0    = ref_sp;
  for (int n = 1; n <= 2; n++)
  begin
    if (jmp[n] && es_need_jump[n] && es_jump_type[n] == JT_CALL)
    begin
      ref_stack[sp0] = es_pc[n][31:2] + 30'd1;
      ref_sp         = sp0 + 3'd1;
    end
    else if (jmp[n] && es_need_jump[n] && es_jump_type[n] == JT_RETURN && !fl[n])
      ref_sp = sp0 - 3'd1;
    if (jmp[n] && es_need_jump[n] && !hit[n])
    begin
      ref_valid[idx[n]] = 1'b1;
      ref_ctr[idx[n]]   = 2'd2;
      ref_tag[idx[n]]   = ref_tag_of(es_pc[n]);
      ref_type[idx[n]]  = es_jump_type[n];
      ref_tgt[idx[n]]   = es_target[n][31:2];
    end
    else if (jmp[n] && hit[n])
    begin
      ref_ctr[idx[n]] = ctr_new[n];
      if (es_need_jump[n])
        ref_tgt[idx[n]] = es_target[n][31:2];
    end
  end
  if (es_flush[1] || es_flush[2] || fl_any)
  begin
    for (int i = 0; i < REF_DEPTH; i++)
      ref_qv[i] = 1'b0;
    ref_qh = '0;
    ref_qt = '0;
  end
  else
  begin
    if (pop_q)
    begin
      ref_qv[ref_qh] = 1'b0;
      ref_qh         = ref_qh + 3'd1;
    end
    if (push_q)
    begin
      ref_q[ref_qt]  = npc[31:2];
      ref_qv[ref_qt] = 1'b1;
      ref_qt         = ref_qt + 3'd1;
    end
  end
endfunction

`endif

// ==== sim/bpu_tb.sv ====
// Prediction unit testbench
`timescale 1ns/1ps

module bpu_tb;
  import bpu_arch_pkg::*;

  localparam int RANDOM_CYCLES = 300;
  localparam int STIM_CYCLES   = RANDOM_CYCLES + 30;  // reset and directed part
  localparam int CYCLE_LIMIT   = 4 * STIM_CYCLES;

  logic       clk;
  logic       reset;
  logic       install;
  pc_t        pc;
  pc_t        next_pc;
  slot_mask_t pc_valid;
  slot_mask_t pc_is_jump;
  logic       bpu_flush;
  pc_t        bpu_jump_pc;
  logic       es_flush     [1:2];
  logic       es_excp      [1:2];
  logic       es_etrn      [1:2];
  pc_t        es_pc        [1:2];
  logic       es_may_jump  [1:2];
  logic       es_need_jump [1:2];
  logic       es_pre_fail  [1:2];
  pc_t        es_target    [1:2];
  jump_type_t es_jump_type [1:2];
  integer     seed;
  int         cycle_count;
  bit         checking;

  `include "bpu_ref_model.svh"

  bpu_top dut_i (
    .clk(clk), .reset(reset), .pc(pc), .install(install),
    .next_pc(next_pc), .pc_valid(pc_valid), .pc_is_jump(pc_is_jump),
    .es_flush_1(es_flush[1]), .es_excp_1(es_excp[1]), .es_etrn_1(es_etrn[1]),
    .es_pc_1(es_pc[1]), .es_may_jump_1(es_may_jump[1]), .es_need_jump_1(es_need_jump[1]),
    .es_pre_fail_1(es_pre_fail[1]), .es_target_1(es_target[1]),
    .es_jump_type_1(es_jump_type[1]),
    .es_flush_2(es_flush[2]), .es_excp_2(es_excp[2]), .es_etrn_2(es_etrn[2]),
    .es_pc_2(es_pc[2]), .es_may_jump_2(es_may_jump[2]), .es_need_jump_2(es_need_jump[2]),
    .es_pre_fail_2(es_pre_fail[2]), .es_target_2(es_target[2]),
    .es_jump_type_2(es_jump_type[2]),
    .bpu_flush(bpu_flush), .bpu_jump_pc(bpu_jump_pc)
  );

  always #4 clk = ~clk;

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    fail_run();
  endtask

  task automatic check_fetch(input pc_t exp_npc, input slot_mask_t exp_valid,
                             input slot_mask_t exp_jump);
    if (next_pc !== exp_npc)
      report_mismatch("next_pc", next_pc, exp_npc);
    if (pc_valid !== exp_valid)
      report_mismatch("pc_valid", 32'(pc_valid), 32'(exp_valid));
    if (pc_is_jump !== exp_jump)
      report_mismatch("pc_is_jump", 32'(pc_is_jump), 32'(exp_jump));
  endtask

  task automatic check_flush(input logic exp_flush, input pc_t exp_pc);
    if (bpu_flush !== exp_flush)
      report_mismatch("bpu_flush", 32'(bpu_flush), 32'(exp_flush));
    if (exp_flush && bpu_jump_pc !== exp_pc)
      report_mismatch("bpu_jump_pc", bpu_jump_pc, exp_pc);
  endtask

  task automatic clear_resolve();
    for (int n = 1; n <= 2; n++)
    begin
      es_flush[n]     = 1'b0;
      es_excp[n]      = 1'b0;
      es_etrn[n]      = 1'b0;
      es_pc[n]        = '0;
      es_may_jump[n]  = 1'b0;
      es_need_jump[n] = 1'b0;
      es_pre_fail[n]  = 1'b0;
      es_target[n]    = '0;
      es_jump_type[n] = JT_DIRECT;
    end
  endtask

  task automatic set_resolve(input int n, input pc_t p, input pc_t tgt, input jump_type_t t,
                             input logic need);
    es_may_jump[n]  = 1'b1;
    es_need_jump[n] = need;
    es_pc[n]        = p;
    es_target[n]    = tgt;
    es_jump_type[n] = t;
  endtask

  // new fetch pc on the falling edge with idle execute slots
  task automatic next_fetch(input pc_t p, input logic inst);
    @(negedge clk);
    clear_resolve();
    pc      = p;
    install = inst;
  endtask

  // small pool of two tags sharing the same indices
  function automatic pc_t rand_pc();
    logic [31:0] r;
    r = $random(seed);
    return ((r[8:6] == 3'd0) ? 32'h0040_1000 : 32'h0001_0000) | (r & 32'h0000_00fc);
  endfunction

  task automatic random_cycle();
    @(negedge clk);
    pc      = rand_pc();
    install = ($random(seed) & 3) == 0;
    for (int n = 1; n <= 2; n++)
    begin
      es_flush[n]     = ($random(seed) & 15) == 0;
      es_excp[n]      = ($random(seed) & 7) == 0;
      es_etrn[n]      = ($random(seed) & 7) == 0;
      es_may_jump[n]  = ($random(seed) & 1) == 1;
      es_need_jump[n] = ($random(seed) & 3) != 0;
      es_pre_fail[n]  = ($random(seed) & 7) == 0;
      es_pc[n]        = rand_pc();
      es_target[n]    = 32'h0001_0000 + ((32'($random(seed)) & 32'h7) << 4);
      es_jump_type[n] = ($random(seed) & 1) ? JT_CALL : JT_DIRECT;
    end
  endtask

  // compare against the model just before each rising edge
  always
  begin
    pc_t        exp_npc;
    slot_mask_t exp_valid;
    slot_mask_t exp_jump;
    bit         exp_flush;
    pc_t        exp_jpc;
    @(negedge clk);
    #2;
    if (checking)
    begin
      ref_fetch(pc, exp_npc, exp_valid, exp_jump);
      check_fetch(exp_npc, exp_valid, exp_jump);
      ref_flush(exp_flush, exp_jpc);
      check_flush(exp_flush, exp_jpc);
      ref_step();
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      fail_run();
    end
  end

  initial
  begin
    pc_t p;
    seed        = 92;
    clk         = 1'b0;
    reset       = 1'b1;
    pc          = '0;
    install     = 1'b1;
    checking    = 1'b0;
    cycle_count = 0;
    clear_resolve();
    ref_reset();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset    = 1'b0;
    checking = 1'b1;

    // empty tables fall through
    for (int k = 0; k < 8; k++)
    begin
      p = 32'h0000_2000 + 32'(k * 4);
      next_fetch(p, 1'b1);
      #2;
      check_fetch({p[31:4], 4'b0000} + 32'd16, 4'b1111 << p[3:2], 4'b0000);
    end

    // taken direct jump trained on slot 2
    next_fetch(32'h0000_2000, 1'b1);
    set_resolve(2, 32'h0001_0108, 32'h0001_0400, JT_DIRECT, 1'b1);
    next_fetch(32'h0001_0100, 1'b1);
    #2;
    check_fetch(32'h0001_0400, 4'b0111, 4'b0100);

    // two not-taken resolves drop the counter
    for (int k = 0; k < 2; k++)
    begin
      next_fetch(32'h0000_2000, 1'b1);
      set_resolve(1, 32'h0001_0108, 32'h0001_0400, JT_DIRECT, 1'b0);
    end
    next_fetch(32'h0001_0100, 1'b1);
    #2;
    check_fetch(32'h0001_0110, 4'b1111, 4'b0000);

    // return entry first so the later call fills the stack
    next_fetch(32'h0000_2000, 1'b1);
    set_resolve(2, 32'h0001_0830, 32'h0001_0204, JT_RETURN, 1'b1);
    next_fetch(32'h0000_2000, 1'b1);
    set_resolve(1, 32'h0001_0200, 32'h0001_0800, JT_CALL, 1'b1);
    next_fetch(32'h0001_0830, 1'b1);
    #2;
    check_fetch(32'h0001_0204, 4'b0001, 4'b0001);

    // queued prediction against a moved and a matching target
    next_fetch(32'h0000_2000, 1'b1);
    set_resolve(2, 32'h0001_0144, 32'h0001_0500, JT_DIRECT, 1'b1);
    next_fetch(32'h0001_0140, 1'b0);
    #2;
    check_fetch(32'h0001_0500, 4'b0011, 4'b0010);
    check_flush(1'b0, '0);
    next_fetch(32'h0000_2000, 1'b0);
    set_resolve(1, 32'h0001_0144, 32'h0001_0600, JT_DIRECT, 1'b1);
    #2;
    check_flush(1'b1, 32'h0001_0600);
    next_fetch(32'h0001_0140, 1'b0);
    #2;
    check_fetch(32'h0001_0600, 4'b0011, 4'b0010);
    next_fetch(32'h0000_2000, 1'b0);
    set_resolve(1, 32'h0001_0144, 32'h0001_0600, JT_DIRECT, 1'b1);
    #2;
    check_flush(1'b0, '0);

    repeat (RANDOM_CYCLES) random_cycle();

    @(negedge clk);
    #2;
    $display("Done: no errors");
    $finish;
  end

endmodule
